// ==== intExec_config.svh ====
`ifndef INTEXEC_CONFIG_SVH
`define INTEXEC_CONFIG_SVH

// Data path and pc width
`define XLEN 32

// Program-order sequence number, wraps around
`define SQN_W 6

// Physical destination tag
`define TAG_W 7

// Architectural register name
`define REGN_W 5

`endif

// ==== intExecPkg.sv ====
`include "intExec_config.svh"

package intExecPkg;

    // Data value or pc
    typedef logic [`XLEN-1:0] Word;

    // Newer or older is decided by the signed difference
    typedef logic [`SQN_W-1:0] SqN;

    typedef logic [`TAG_W-1:0] Tag;

    // Zero means the micro-op writes no register
    typedef logic [`REGN_W-1:0] RegName;

    // Completion code returned with the result
    typedef logic [2:0] Flags;

    localparam Flags FLAGS_NONE = 3'd0;
    localparam Flags FLAGS_EXCEPT = 3'd2;

    typedef enum logic [5:0] {
        // RV32I base
        INT_ADD, INT_SUB, INT_XOR, INT_OR, INT_AND,
        INT_SLL, INT_SRL, INT_SRA,
        INT_SLT, INT_SLTU,
        INT_LUI, INT_AUIPC,

        // Zba address generation
        INT_SH1ADD, INT_SH2ADD, INT_SH3ADD,

        // Zbb logic, counts and min/max
        INT_ANDN, INT_ORN, INT_XNOR,
        INT_CLZ, INT_CTZ, INT_CPOP,
        INT_MIN, INT_MAX, INT_MINU, INT_MAXU,
        INT_SEXT_B, INT_SEXT_H, INT_ZEXT_H,
        INT_REV8, INT_ORC_B,

        // Jumps and conditional branches
        INT_JAL, INT_JALR,
        INT_BEQ, INT_BNE,
        INT_BLT, INT_BGE,
        INT_BLTU, INT_BGEU,

        // Speculated return address check
        INT_VRET,

        INT_SYS,
        INT_UNDEF
    } IntOp;

endpackage

// ==== uopIf.sv ====
`timescale 1ns/10ps

interface uopIf;
    import intExecPkg::*;

    logic valid;
    IntOp opcode;
    Word srcA;
    Word srcB;
    Word imm;
    Word pc;
    SqN sqN;
    Tag tagDst;
    RegName nmDst;
    logic compressed;
    logic branchPred;

    modport issue (
        output valid, opcode, srcA, srcB, imm, pc,
        output sqN, tagDst, nmDst, compressed, branchPred
    );

    modport exec (
        input valid, opcode, srcA, srcB, imm, pc,
        input sqN, tagDst, nmDst, compressed, branchPred
    );
endinterface

interface resIf;
    import intExecPkg::*;

    logic valid;
    Word result;
    Tag tagDst;
    RegName nmDst;
    SqN sqN;
    Flags flags;
    logic redirect;
    Word dstPc;

    modport alu (output valid, result, tagDst, nmDst, sqN, flags, redirect, dstPc);

    modport wb (input valid, result, tagDst, nmDst, sqN, flags, redirect, dstPc);
endinterface

// ==== issueStage.sv ====
`timescale 1ns/10ps

module issueStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  intExecPkg::IntOp     inOpcode,
    input  intExecPkg::Word      inSrcA,
    input  intExecPkg::Word      inSrcB,
    input  intExecPkg::Word      inImm,
    input  intExecPkg::Word      inPc,
    input  intExecPkg::SqN       inSqN,
    input  intExecPkg::Tag       inTagDst,
    input  intExecPkg::RegName   inNmDst,
    input  logic                 inCompressed,
    input  logic                 inBranchPred,
    input  logic                 wbStall,
    input  logic                 invalidate,
    input  intExecPkg::SqN       invalidateSqN,
    uopIf.issue                  uop
);
    import intExecPkg::*;

    logic heldValid;
    logic squashIn;
    logic squashHeld;

    // Positive wrapped difference means a is younger than b
    function automatic logic isNewer(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    assign squashIn = invalidate && isNewer(inSqN, invalidateSqN);
    assign squashHeld = invalidate && isNewer(uop.sqN, invalidateSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
        end else if (wbStall) begin
            heldValid <= heldValid && !squashHeld;
        end else begin
            heldValid <= inValid && !squashIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!wbStall) begin
            uop.opcode <= inOpcode;
            uop.srcA <= inSrcA;
            uop.srcB <= inSrcB;
            uop.imm <= inImm;
            uop.pc <= inPc;
            uop.sqN <= inSqN;
            uop.tagDst <= inTagDst;
            uop.nmDst <= inNmDst;
            uop.compressed <= inCompressed;
            uop.branchPred <= inBranchPred;
        end
    end

    // A squash in the same cycle keeps the held op out of the result register
    assign uop.valid = heldValid && !squashHeld;

endmodule

// ==== intAlu.sv ====
`timescale 1ns/10ps
`include "intExec_config.svh"

module intAlu (
    uopIf.exec uop,
    resIf.alu  res
);
    import intExecPkg::*;

    localparam int CntW = $clog2(`XLEN) + 1;
    localparam int ShW = $clog2(`XLEN);

    Word srcA;
    Word srcB;
    Word imm;
    Word srcARev;
    Word cntIn;
    Word revBytes;
    Word orcBytes;
    Word pcPlus2;
    Word pcPlus4;
    Word pcNext;
    Word brOffset;
    Word result;
    Word dstPc;
    Flags flags;
    logic [CntW-1:0] zeroCnt;
    logic [CntW-1:0] popCnt;
    logic [ShW-1:0] shamt;
    logic lessThan;
    logic lessThanU;
    logic isCondBranch;
    logic taken;
    logic redirect;

    assign srcA = uop.srcA;
    assign srcB = uop.srcB;
    assign imm = uop.imm;
    assign shamt = srcB[ShW-1:0];

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;

    assign pcPlus2 = uop.pc + Word'(2);
    assign pcPlus4 = uop.pc + Word'(4);
    assign pcNext = uop.compressed ? pcPlus2 : pcPlus4;
    assign brOffset = {{(`XLEN-13){imm[12]}}, imm[12:0]};

    // ctz is clz of the bit-reversed operand
    always_comb begin
        for (int i = 0; i < `XLEN; i++) begin
            srcARev[i] = srcA[`XLEN-1-i];
        end
    end

    assign cntIn = (uop.opcode == INT_CLZ) ? srcA : srcARev;

    always_comb begin
        logic found;
        found = 1'b0;
        zeroCnt = CntW'(`XLEN);
        for (int i = `XLEN-1; i >= 0; i--) begin
            if (!found && cntIn[i]) begin
                found = 1'b1;
                zeroCnt = CntW'(`XLEN-1-i);
            end
        end
    end

    always_comb begin
        popCnt = '0;
        for (int i = 0; i < `XLEN; i++) begin
            popCnt = popCnt + CntW'(srcA[i]);
        end
    end

    always_comb begin
        for (int b = 0; b < `XLEN/8; b++) begin
            revBytes[8*b +: 8] = srcA[`XLEN-8-8*b +: 8];
            orcBytes[8*b +: 8] = {8{|srcA[8*b +: 8]}};
        end
    end

    always_comb begin
        case (uop.opcode)
            INT_ADD: result = srcA + srcB;
            INT_SUB: result = srcA - srcB;
            INT_XOR: result = srcA ^ srcB;
            INT_OR: result = srcA | srcB;
            INT_AND: result = srcA & srcB;
            INT_SLL: result = srcA << shamt;
            INT_SRL: result = srcA >> shamt;
            INT_SRA: result = Word'($signed(srcA) >>> shamt);
            INT_SLT: result = Word'(lessThan);
            INT_SLTU: result = Word'(lessThanU);
            INT_LUI: result = srcB;
            INT_AUIPC: result = uop.pc + imm;
            INT_SH1ADD: result = srcB + (srcA << 1);
            INT_SH2ADD: result = srcB + (srcA << 2);
            INT_SH3ADD: result = srcB + (srcA << 3);
            INT_ANDN: result = srcA & ~srcB;
            INT_ORN: result = srcA | ~srcB;
            INT_XNOR: result = srcA ^ ~srcB;
            INT_CLZ, INT_CTZ: result = Word'(zeroCnt);
            INT_CPOP: result = Word'(popCnt);
            INT_MIN: result = lessThan ? srcA : srcB;
            INT_MAX: result = lessThan ? srcB : srcA;
            INT_MINU: result = lessThanU ? srcA : srcB;
            INT_MAXU: result = lessThanU ? srcB : srcA;
            INT_SEXT_B: result = {{(`XLEN-8){srcA[7]}}, srcA[7:0]};
            INT_SEXT_H: result = {{(`XLEN-16){srcA[15]}}, srcA[15:0]};
            INT_ZEXT_H: result = {{(`XLEN-16){1'b0}}, srcA[15:0]};
            INT_REV8: result = revBytes;
            INT_ORC_B: result = orcBytes;
            // Link address
            INT_JAL, INT_JALR: result = pcNext;
            default: result = '0;
        endcase

        case (uop.opcode)
            INT_UNDEF: flags = FLAGS_EXCEPT;
            INT_SYS: flags = imm[2:0];
            default: flags = FLAGS_NONE;
        endcase
    end

    assign isCondBranch = uop.opcode inside {INT_BEQ, INT_BNE, INT_BLT, INT_BGE,
                                             INT_BLTU, INT_BGEU};

    always_comb begin
        case (uop.opcode)
            INT_BEQ: taken = (srcA == srcB);
            INT_BNE: taken = (srcA != srcB);
            INT_BLT: taken = lessThan;
            INT_BGE: taken = !lessThan;
            INT_BLTU: taken = lessThanU;
            INT_BGEU: taken = !lessThanU;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect = 1'b0;
        dstPc = pcNext;
        if (uop.opcode == INT_JAL) begin
            // Always taken, so only a not-taken prediction is wrong
            redirect = !uop.branchPred;
            dstPc = uop.pc + imm;
        end else if (uop.opcode == INT_JALR) begin
            redirect = 1'b1;
            dstPc = srcA + srcB;
        end else if (uop.opcode == INT_VRET) begin
            redirect = (srcA != srcB);
            dstPc = srcA;
        end else if (isCondBranch) begin
            redirect = (taken != uop.branchPred);
            dstPc = taken ? uop.pc + brOffset : pcNext;
        end
    end

    assign res.valid = uop.valid;
    assign res.result = result;
    assign res.tagDst = uop.tagDst;
    assign res.nmDst = uop.nmDst;
    assign res.sqN = uop.sqN;
    assign res.flags = flags;
    assign res.redirect = redirect;
    assign res.dstPc = dstPc;

endmodule

// ==== resultStage.sv ====
`timescale 1ns/10ps

module resultStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wbStall,
    resIf.wb                     res,
    output logic                 resValid,
    output intExecPkg::Word      resResult,
    output intExecPkg::Tag       resTagDst,
    output intExecPkg::RegName   resNmDst,
    output intExecPkg::SqN       resSqN,
    output intExecPkg::Flags     resFlags,
    output logic                 brRedirect,
    output intExecPkg::Word      brDstPc,
    output intExecPkg::SqN       brSqN
);
    import intExecPkg::*;

    SqN sqNQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
            brRedirect <= 1'b0;
        end else if (!wbStall) begin
            resValid <= res.valid;
            // Redirect only travels with a live result
            brRedirect <= res.valid && res.redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (!wbStall) begin
            resResult <= res.result;
            resTagDst <= res.tagDst;
            resNmDst <= res.nmDst;
            resFlags <= res.flags;
            sqNQ <= res.sqN;
            brDstPc <= res.dstPc;
        end
    end

    // Result record and redirect share the micro-op's sequence number
    assign resSqN = sqNQ;
    assign brSqN = sqNQ;

endmodule

// ==== intExecUnit.sv ====
`timescale 1ns/10ps

module intExecUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  intExecPkg::IntOp     inOpcode,
    input  intExecPkg::Word      inSrcA,
    input  intExecPkg::Word      inSrcB,
    input  intExecPkg::Word      inImm,
    input  intExecPkg::Word      inPc,
    input  intExecPkg::SqN       inSqN,
    input  intExecPkg::Tag       inTagDst,
    input  intExecPkg::RegName   inNmDst,
    input  logic                 inCompressed,
    input  logic                 inBranchPred,
    input  logic                 wbStall,
    input  logic                 invalidate,
    input  intExecPkg::SqN       invalidateSqN,
    output logic                 resValid,
    output intExecPkg::Word      resResult,
    output intExecPkg::Tag       resTagDst,
    output intExecPkg::RegName   resNmDst,
    output intExecPkg::SqN       resSqN,
    output intExecPkg::Flags     resFlags,
    output logic                 brRedirect,
    output intExecPkg::Word      brDstPc,
    output intExecPkg::SqN       brSqN
);

    uopIf uopBus ();
    resIf resBus ();

    issueStage issue (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inOpcode(inOpcode),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inImm(inImm),
        .inPc(inPc),
        .inSqN(inSqN),
        .inTagDst(inTagDst),
        .inNmDst(inNmDst),
        .inCompressed(inCompressed),
        .inBranchPred(inBranchPred),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .uop(uopBus.issue)
    );

    intAlu alu (
        .uop(uopBus.exec),
        .res(resBus.alu)
    );

    resultStage result (
        .clk(clk),
        .rst(rst),
        .wbStall(wbStall),
        .res(resBus.wb),
        .resValid(resValid),
        .resResult(resResult),
        .resTagDst(resTagDst),
        .resNmDst(resNmDst),
        .resSqN(resSqN),
        .resFlags(resFlags),
        .brRedirect(brRedirect),
        .brDstPc(brDstPc),
        .brSqN(brSqN)
    );

endmodule

// ==== intExecAsserts.sv ====
`timescale 1ns/10ps

module intExecAsserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 inValid,
    input logic                 wbStall,
    input logic                 invalidate,
    input logic                 resValid,
    input logic                 brRedirect,
    input intExecPkg::Word      resResult,
    input intExecPkg::Word      brDstPc,
    input intExecPkg::SqN       resSqN,
    input intExecPkg::Tag       resTagDst,
    input intExecPkg::RegName   resNmDst,
    input intExecPkg::Flags     resFlags,
    input intExecPkg::SqN       brSqN
);
    int failCount = 0;

    // Accepted op with no stall or invalidate reaches the output two edges later
    twoEdgeLatency: assert property (@(posedge clk) disable iff (rst)
        $past(inValid) && !$past(wbStall) && !$past(invalidate) && !$past(rst)
            && !wbStall && !invalidate |=> resValid)
    else begin
        failCount++;
        $error("resValid missing two edges after an accepted micro-op");
    end

    stallHold: assert property (@(posedge clk) disable iff (rst)
        $past(wbStall) && !$past(rst) |-> $stable(resValid) && $stable(resResult)
            && $stable(resSqN) && $stable(brRedirect) && $stable(brDstPc)
            && $stable(resTagDst) && $stable(resNmDst) && $stable(resFlags)
            && $stable(brSqN))
    else begin
        failCount++;
        $error("Result outputs changed while wbStall was high");
    end

    resetState: assert property (@(posedge clk) $past(rst) |-> !resValid && !brRedirect)
    else begin
        failCount++;
        $error("resValid or brRedirect high right after reset");
    end

    redirectWithResult: assert property (@(posedge clk) disable iff (rst)
        brRedirect |-> resValid)
    else begin
        failCount++;
        $error("brRedirect raised without resValid");
    end

    // Issuing side keeps inValid low during back-pressure
    noIssueInStall: assert property (@(posedge clk) disable iff (rst) wbStall |-> !inValid)
    else begin
        failCount++;
        $error("inValid high while wbStall was high");
    end

endmodule

bind intExecUnit intExecAsserts asserts (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .wbStall(wbStall),
    .invalidate(invalidate),
    .resValid(resValid),
    .brRedirect(brRedirect),
    .resResult(resResult),
    .brDstPc(brDstPc),
    .resSqN(resSqN),
    .resTagDst(resTagDst),
    .resNmDst(resNmDst),
    .resFlags(resFlags),
    .brSqN(brSqN)
);

// ==== intExecTb.sv ====
`timescale 1ns/10ps
`include "intExec_config.svh"

module intExecTb;
    import intExecPkg::*;

    typedef struct packed {
        Word result;
        logic chkResult;
        Flags flags;
        logic redirect;
        Word dstPc;
        SqN sqN;
        Tag tagDst;
        RegName nmDst;
    } ExpRec;

    localparam int OpCount = int'(INT_UNDEF) + 1;

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    IntOp inOpcode;
    Word inSrcA;
    Word inSrcB;
    Word inImm;
    Word inPc;
    SqN inSqN;
    Tag inTagDst;
    RegName inNmDst;
    logic inCompressed;
    logic inBranchPred;
    logic wbStall;
    logic invalidate;
    SqN invalidateSqN;
    logic resValid;
    Word resResult;
    Tag resTagDst;
    RegName resNmDst;
    SqN resSqN;
    Flags resFlags;
    logic brRedirect;
    Word brDstPc;
    SqN brSqN;

    integer seed;
    int errors = 0;
    int timeouts = 0;
    SqN nextSqN = '0;
    logic advanced = 1'b0;
    logic issueHeld = 1'b0;
    ExpRec expQ[$];

    intExecUnit DUT (.*);

    always #20 clk = ~clk;

    // Younger when the wrapped difference is nonzero with a clear sign bit
    function automatic logic youngerThan(input SqN a, input SqN b);
        SqN d;
        d = a - b;
        return (d != '0) && !d[`SQN_W-1];
    endfunction

    function automatic ExpRec refModel(input IntOp op, input Word a, input Word b,
                                       input Word im, input Word pc, input logic c,
                                       input logic pred);
        ExpRec e;
        Word link;
        logic tk;
        int n;
        e = '0;
        e.chkResult = 1'b1;
        link = c ? pc + 32'd2 : pc + 32'd4;
        n = 0;
        case (op)
            INT_ADD: e.result = a + b;
            INT_SUB: e.result = a - b;
            INT_XOR: e.result = a ^ b;
            INT_OR: e.result = a | b;
            INT_AND: e.result = a & b;
            INT_SLL: e.result = a << b[4:0];
            INT_SRL: e.result = a >> b[4:0];
            INT_SRA: e.result = Word'($signed(a) >>> b[4:0]);
            INT_SLT: e.result = Word'($signed(a) < $signed(b));
            INT_SLTU: e.result = Word'(a < b);
            INT_LUI: e.result = b;
            INT_AUIPC: e.result = pc + im;
            INT_SH1ADD: e.result = (a << 1) + b;
            INT_SH2ADD: e.result = (a << 2) + b;
            INT_SH3ADD: e.result = (a << 3) + b;
            INT_ANDN: e.result = a & ~b;
            INT_ORN: e.result = a | ~b;
            INT_XNOR: e.result = ~(a ^ b);
            INT_CLZ: begin
                while (n < `XLEN && a[`XLEN-1-n] == 1'b0)
                    n++;
                e.result = Word'(n);
            end
            INT_CTZ: begin
                while (n < `XLEN && a[n] == 1'b0)
                    n++;
                e.result = Word'(n);
            end
            INT_CPOP: e.result = Word'($countones(a));
            INT_MIN: e.result = ($signed(a) < $signed(b)) ? a : b;
            INT_MAX: e.result = ($signed(a) < $signed(b)) ? b : a;
            INT_MINU: e.result = (a < b) ? a : b;
            INT_MAXU: e.result = (a < b) ? b : a;
            INT_SEXT_B: e.result = {{24{a[7]}}, a[7:0]};
            INT_SEXT_H: e.result = {{16{a[15]}}, a[15:0]};
            INT_ZEXT_H: e.result = {16'h0, a[15:0]};
            INT_REV8: e.result = {a[7:0], a[15:8], a[23:16], a[31:24]};
            INT_ORC_B: begin
                for (int i = 0; i < 4; i++)
                    e.result[8*i +: 8] = (a[8*i +: 8] != 8'd0) ? 8'hff : 8'h00;
            end
            INT_JAL: begin
                e.result = link;
                e.redirect = !pred;
                e.dstPc = pc + im;
            end
            INT_JALR: begin
                e.result = link;
                e.redirect = 1'b1;
                e.dstPc = a + b;
            end
            INT_VRET: begin
                e.chkResult = 1'b0;
                e.redirect = (a != b);
                e.dstPc = a;
            end
            INT_SYS: begin
                e.chkResult = 1'b0;
                e.flags = im[2:0];
            end
            INT_UNDEF: begin
                e.chkResult = 1'b0;
                e.flags = FLAGS_EXCEPT;
            end
            default: begin
                // Conditional branches
                case (op)
                    INT_BEQ: tk = (a == b);
                    INT_BNE: tk = (a != b);
                    INT_BLT: tk = ($signed(a) < $signed(b));
                    INT_BGE: tk = ($signed(a) >= $signed(b));
                    INT_BLTU: tk = (a < b);
                    default: tk = (a >= b);
                endcase
                e.chkResult = 1'b0;
                e.redirect = (tk != pred);
                e.dstPc = tk ? pc + {{19{im[12]}}, im[12:0]} : link;
            end
        endcase
        return e;
    endfunction

    task automatic checkValue(input string name, input Word actual, input Word expected);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Tracks which expected records are still in the issue register
    always @(posedge clk) begin
        ExpRec e;
        advanced <= !wbStall && !rst;
        if (rst) begin
            expQ.delete();
            issueHeld = 1'b0;
        end else begin
            if (issueHeld && invalidate && youngerThan(expQ[$].sqN, invalidateSqN)) begin
                void'(expQ.pop_back());
                issueHeld = 1'b0;
            end
            if (!wbStall) begin
                issueHeld = 1'b0;
                if (inValid && !(invalidate && youngerThan(inSqN, invalidateSqN))) begin
                    e = refModel(inOpcode, inSrcA, inSrcB, inImm, inPc, inCompressed,
                                 inBranchPred);
                    e.sqN = inSqN;
                    e.tagDst = inTagDst;
                    e.nmDst = inNmDst;
                    expQ.push_back(e);
                    issueHeld = 1'b1;
                end
            end
        end
    end

    always @(negedge clk) begin
        ExpRec e;
        if (advanced && resValid) begin
            if (expQ.size() == 0) begin
                $display("Unexpected result with sqN %0d at %0t", resSqN, $time);
                errors++;
            end else begin
                e = expQ.pop_front();
                checkValue("resSqN", Word'(resSqN), Word'(e.sqN));
                checkValue("brSqN", Word'(brSqN), Word'(e.sqN));
                checkValue("resTagDst", Word'(resTagDst), Word'(e.tagDst));
                checkValue("resNmDst", Word'(resNmDst), Word'(e.nmDst));
                checkValue("resFlags", Word'(resFlags), Word'(e.flags));
                checkValue("brRedirect", Word'(brRedirect), Word'(e.redirect));
                if (e.chkResult)
                    checkValue("resResult", resResult, e.result);
                if (e.redirect)
                    checkValue("brDstPc", brDstPc, e.dstPc);
            end
        end
    end

    task automatic issueOp(input IntOp op, input Word a, input Word b);
        @(posedge clk);
        inValid <= 1'b1;
        inOpcode <= op;
        inSrcA <= a;
        inSrcB <= b;
        inImm <= Word'($random(seed));
        inPc <= Word'($random(seed)) & ~Word'(1);
        inSqN <= nextSqN;
        inTagDst <= Tag'($random(seed));
        inNmDst <= RegName'($random(seed));
        inCompressed <= 1'($random(seed));
        inBranchPred <= 1'($random(seed));
        invalidate <= 1'b0;
        nextSqN = nextSqN + SqN'(1);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        inValid <= 1'b0;
        invalidate <= 1'b0;
    endtask

    // Back-pressure for n cycles, optionally squashing the held op mid-stall
    task automatic stallCycles(input int n, input logic squash, input SqN limitSqN);
        @(posedge clk);
        inValid <= 1'b0;
        invalidate <= 1'b0;
        wbStall <= 1'b1;
        repeat (2) @(posedge clk);
        invalidate <= squash;
        invalidateSqN <= limitSqN;
        @(posedge clk);
        invalidate <= 1'b0;
        repeat (n) @(posedge clk);
        wbStall <= 1'b0;
    endtask

    task automatic drainResults(input int limit);
        int n;
        idleCycle();
        n = 0;
        while (n < limit) begin
            @(negedge clk);
            if (expQ.size() == 0)
                break;
            n++;
        end
        if (expQ.size() != 0) begin
            $display("Timeout: %0d expected results never appeared", expQ.size());
            timeouts++;
            expQ.delete();
        end
    endtask

    initial begin
        Word edgeVals[6];
        seed = 32'h9f235e91;
        edgeVals = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h1, 32'h00ff0f00};
        rst = 1'b1;
        inValid = 1'b0;
        inOpcode = INT_ADD;
        inSrcA = '0;
        inSrcB = '0;
        inImm = '0;
        inPc = '0;
        inSqN = '0;
        inTagDst = '0;
        inNmDst = '0;
        inCompressed = 1'b0;
        inBranchPred = 1'b0;
        wbStall = 1'b0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Every op against every pair of edge operands, back to back
        for (int k = 0; k < OpCount; k++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++)
                    issueOp(IntOp'(k), edgeVals[i], edgeVals[j]);
            end
        end
        drainResults(20);

        // Squash across the sequence-number wrap, then an older limit that keeps all
        nextSqN = SqN'(62);
        issueOp(INT_ADD, 32'd1, 32'd2);
        issueOp(INT_SUB, 32'd5, 32'd3);
        issueOp(INT_XOR, 32'd7, 32'd1);
        invalidate <= 1'b1;
        invalidateSqN <= SqN'(62);
        issueOp(INT_OR, 32'd8, 32'd1);
        issueOp(INT_AND, 32'd3, 32'd6);
        issueOp(INT_SLT, 32'd3, 32'd6);
        invalidate <= 1'b1;
        invalidateSqN <= SqN'(5);
        drainResults(20);

        issueOp(INT_ADD, 32'd10, 32'd20);
        issueOp(INT_CLZ, 32'h00010000, 32'd0);
        stallCycles(4, 1'b0, '0);
        issueOp(INT_JAL, 32'd0, 32'd0);
        stallCycles(3, 1'b1, nextSqN - SqN'(2));
        drainResults(20);

        for (int n = 0; n < 800; n++) begin
            issueOp(IntOp'($unsigned($random(seed)) % OpCount), Word'($random(seed)),
                    Word'($random(seed)));
            if (($random(seed) & 31) == 0) begin
                invalidate <= 1'b1;
                invalidateSqN <= SqN'($random(seed));
            end
            if (($random(seed) & 15) == 0)
                stallCycles(1 + ($random(seed) & 3), 1'($random(seed)), SqN'($random(seed)));
        end
        drainResults(20);

        $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, DUT.asserts.failCount);
        if (errors == 0 && timeouts == 0 && DUT.asserts.failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
intExecPkg.sv
uopIf.sv
issueStage.sv
intAlu.sv
resultStage.sv
intExecUnit.sv
intExecAsserts.sv
intExecTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= intExecTb
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
ERRLIMIT ?= 1000
JOBS ?= 0
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only when the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) +verilator+error+limit+$(ERRLIMIT) | tee /dev/stderr \
		| grep -x "RESULT: PASS" > /dev/null

clean:
	rm -rf $(OBJDIR)
